/* list.f */
+incdir+common
common/cache_dma_pkg.sv
common/dma_mem_if.sv
hdl/dma_fifo.sv
hdl/cache_data_mem.sv
cache_dma/cache_dma_engine.sv
hdl/cache_dma_top.sv
testbench/cache_dma_asserts.sv
testbench/cache_dma_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the cache DMA testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
  -f list.f \
  --top-module cache_dma_tb \
  -Mdir obj_dir -o cache_dma_sim

# simulation status is judged from the log below
./obj_dir/cache_dma_sim 2>&1 | tee sim.log

if grep -q "^Finished with no errors$" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi

/* testbench/cache_dma_tb.sv */
// cache DMA testbench, random miss controller and external memory checked against a block model
`timescale 1ns/1ps
`include "cache_dma_consts.svh"

module cache_dma_tb;

  import cache_dma_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_CMDS   = 200;
  localparam int CMD_CYCLES = 40;
  // bound for one command, below its share of the watchdog time
  localparam int CMD_LIMIT  = 32;

  logic                   clk_i;
  logic                   reset_i;
  dma_cmd_e               dma_cmd_i;
  logic [`WAY_WIDTH-1:0]  dma_way_i;
  logic [`ADDR_WIDTH-1:0] dma_addr_i;
  logic                   dma_st_tag_miss_op_i;
  logic                   dma_fill_then_evict_i;
  logic                   uncached_op_v_i;
  logic [`DATA_WIDTH-1:0] data_v_r_i;
  logic                   done_o;
  logic [`DATA_WIDTH-1:0] snoop_word_o;
  dma_pkt_s               dma_pkt_o;
  logic                   dma_pkt_v_o;
  logic                   dma_pkt_yumi_i;
  logic [`DATA_WIDTH-1:0] dma_data_i;
  logic                   dma_data_v_i;
  logic                   dma_data_ready_and_o;
  logic [`DATA_WIDTH-1:0] dma_data_o;
  logic                   dma_data_v_o;
  logic                   dma_data_yumi_i;
  logic                   dma_evict_o;

  integer                 seed;
  int                     value_errors;
  int                     done_errors;
  int                     other_errors;
  // model of the data memory, unknown until a block is filled
  logic [`DATA_WIDTH-1:0] model_mem [`WAYS][`SETS][`BLOCK_WORDS];
  logic                   filled [`WAYS][`SETS];
  logic [`DATA_WIDTH-1:0] feed_buf [`BLOCK_WORDS];
  logic [`DATA_WIDTH-1:0] expect_buf [`BLOCK_WORDS];

  cache_dma_top cache_dma_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // watchdog
  initial begin
    #((NUM_CMDS * CMD_CYCLES + 10) * CLK_PERIOD);
    $display("timeout: the run did not complete within %0d cycles", NUM_CMDS * CMD_CYCLES + 10);
    $display("Finished with errors");
    $finish;
  end

  function automatic logic rand_bit();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  function automatic logic [`DATA_WIDTH-1:0] rand_word();
    logic [31:0] r;
    r = $random(seed);
    return r;
  endfunction

  task automatic check_pkt(input dma_pkt_s got, input dma_pkt_s exp);
    if (got !== exp) begin
      $display("[FAIL] dma_pkt_o got %h expected %h at %0t", got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic check_word(input string name, input logic [`DATA_WIDTH-1:0] got,
                            input logic [`DATA_WIDTH-1:0] exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("[FAIL] %s got %h expected %h at %0t", name, got, exp, $time);
      value_errors++;
    end
  endtask

  task automatic check_done(input logic seen, input dma_cmd_e cmd);
    if (!seen) begin
      $display("done_o never arrived for command %s at %0t", cmd.name(), $time);
      done_errors++;
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // command level with a random address placed in the given set
  task automatic start_cmd(input dma_cmd_e cmd, input logic [`WAY_WIDTH-1:0] way,
                           input logic [`SET_WIDTH-1:0] set, input logic uncached);
    dma_cmd_i             = cmd;
    dma_way_i             = way;
    dma_addr_i            = rand_word();
    dma_addr_i[`BLOCK_OFFSET_WIDTH +: `SET_WIDTH] = set;
    dma_st_tag_miss_op_i  = rand_bit();
    dma_fill_then_evict_i = rand_bit();
    uncached_op_v_i       = uncached;
  endtask

  // external memory side delivering feed_buf words with random gaps
  task automatic feed_words(input int n, output logic seen);
    int sent;
    int cycles;
    sent   = 0;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < CMD_LIMIT) begin
      dma_data_v_i = (sent < n) && rand_bit();
      dma_data_i   = feed_buf[sent % `BLOCK_WORDS];
      @(negedge clk_i);
      if (dma_data_v_i && dma_data_ready_and_o) begin
        sent++;
      end
      seen = done_o;
      next_cycle();
      cycles++;
    end
    dma_cmd_i    = e_dma_nop;
    dma_data_v_i = 1'b0;
  endtask

  // outgoing words taken under random yumi, compared with expect_buf in order
  task automatic drain_words(input int n, input logic evict, output logic seen);
    int   taken;
    int   cycles;
    logic exp_evict;
    taken  = 0;
    cycles = 0;
    seen   = 1'b0;
    while ((!seen || taken < n) && cycles < CMD_LIMIT) begin
      dma_data_yumi_i = dma_data_v_o && rand_bit();
      @(negedge clk_i);
      // evict flag from the cycle after the command starts through done
      exp_evict = evict && (cycles > 0) && !seen;
      check_flag("dma_evict_o", dma_evict_o, exp_evict);
      if (done_o) begin
        if (seen) begin
          $display("done_o pulsed twice for one command at %0t", $time);
          other_errors++;
        end
        seen = 1'b1;
      end
      if (dma_data_yumi_i) begin
        if (taken < n) begin
          check_word("dma_data_o", dma_data_o, expect_buf[taken]);
        end else begin
          $display("more outgoing words than the command sends at %0t", $time);
          other_errors++;
        end
        taken++;
      end
      next_cycle();
      if (seen) begin
        dma_cmd_i = e_dma_nop;
      end
      cycles++;
    end
    if (taken < n) begin
      $display("only %0d of %0d outgoing words arrived at %0t", taken, n, $time);
      other_errors++;
    end
    dma_cmd_i       = e_dma_nop;
    dma_data_yumi_i = 1'b0;
  endtask

  task automatic send_addr(input dma_cmd_e cmd);
    dma_pkt_s exp;
    logic     seen;
    logic     taken;
    int       cycles;
    seen   = 1'b0;
    taken  = 1'b0;
    cycles = 0;
    start_cmd(cmd, rand_bit(), `SET_WIDTH'(rand_word()),
              (cmd == e_dma_send_evict_addr) && rand_bit());
    exp                = '0;
    exp.write_not_read = (cmd == e_dma_send_evict_addr);
    if (cmd == e_dma_send_fill_addr) begin
      exp.write_validate = dma_st_tag_miss_op_i;
      exp.evict_pending  = dma_fill_then_evict_i;
    end
    exp.uncached_op = uncached_op_v_i;
    exp.way_id      = dma_way_i;
    exp.addr        = dma_addr_i;
    exp.addr[`BYTE_OFFSET_WIDTH-1:0] = '0;
    if (!uncached_op_v_i) begin
      exp.addr[`BLOCK_OFFSET_WIDTH-1:0] = '0;
    end
    while (!taken && cycles < CMD_LIMIT) begin
      dma_pkt_yumi_i = rand_bit();
      @(negedge clk_i);
      if (!dma_pkt_v_o || done_o !== dma_pkt_yumi_i) begin
        $display("packet valid or done_o wrong for %s at %0t", cmd.name(), $time);
        other_errors++;
      end
      if (dma_pkt_yumi_i) begin
        check_pkt(dma_pkt_o, exp);
        taken = 1'b1;
      end
      seen = seen | done_o;
      next_cycle();
      cycles++;
    end
    dma_cmd_i      = e_dma_nop;
    dma_pkt_yumi_i = 1'b0;
    check_done(seen, cmd);
  endtask

  task automatic fill_block(input logic [`WAY_WIDTH-1:0] way, input logic [`SET_WIDTH-1:0] set);
    logic seen;
    for (int i = 0; i < `BLOCK_WORDS; i++) begin
      feed_buf[i] = rand_word();
    end
    start_cmd(e_dma_get_fill_data, way, set, 1'b0);
    feed_words(`BLOCK_WORDS, seen);
    check_done(seen, e_dma_get_fill_data);
    if (seen) begin
      for (int i = 0; i < `BLOCK_WORDS; i++) begin
        model_mem[way][set][i] = feed_buf[i];
      end
      filled[way][set] = 1'b1;
    end
    // the requested word was captured while the block streamed in
    check_word("snoop_word_o", snoop_word_o,
               feed_buf[dma_addr_i[`BYTE_OFFSET_WIDTH +: `WORD_OFFSET_WIDTH]]);
  endtask

  task automatic evict_block(input logic [`WAY_WIDTH-1:0] way, input logic [`SET_WIDTH-1:0] set);
    logic seen;
    for (int i = 0; i < `BLOCK_WORDS; i++) begin
      expect_buf[i] = model_mem[way][set][i];
    end
    start_cmd(e_dma_send_evict_data, way, set, 1'b0);
    drain_words(`BLOCK_WORDS, 1'b1, seen);
    check_done(seen, e_dma_send_evict_data);
  endtask

  task automatic recv_io_word();
    logic seen;
    feed_buf[0] = rand_word();
    start_cmd(e_dma_recv_io_data, rand_bit(), `SET_WIDTH'(rand_word()), 1'b1);
    feed_words(1, seen);
    check_done(seen, e_dma_recv_io_data);
    check_word("snoop_word_o", snoop_word_o, feed_buf[0]);
  endtask

  task automatic send_io_word();
    logic seen;
    expect_buf[0] = rand_word();
    data_v_r_i    = expect_buf[0];
    start_cmd(e_dma_send_io_data, rand_bit(), `SET_WIDTH'(rand_word()), 1'b1);
    drain_words(1, 1'b0, seen);
    check_done(seen, e_dma_send_io_data);
  endtask

  // a nop cycle between commands, no late done pulse allowed
  task automatic idle_cycle();
    @(negedge clk_i);
    if (done_o) begin
      $display("done_o pulsed again after the command had completed at %0t", $time);
      other_errors++;
    end
    next_cycle();
  endtask

  task automatic run_random_cmd();
    logic [31:0]           r;
    int unsigned           pick;
    logic [`WAY_WIDTH-1:0] way;
    logic [`SET_WIDTH-1:0] set;
    r    = $random(seed);
    pick = r % 6;
    way  = r[8 +: `WAY_WIDTH];
    set  = r[12 +: `SET_WIDTH];
    case (pick)
      0: send_addr(e_dma_send_fill_addr);
      1: send_addr(e_dma_send_evict_addr);
      2: fill_block(way, set);
      3: begin
        // only filled blocks are evicted
        if (filled[way][set]) begin
          evict_block(way, set);
        end else begin
          fill_block(way, set);
        end
      end
      4: recv_io_word();
      default: send_io_word();
    endcase
    idle_cycle();
  endtask

  initial begin
    seed                  = 24871;
    value_errors          = 0;
    done_errors           = 0;
    other_errors          = 0;
    reset_i               = 1'b1;
    dma_cmd_i             = e_dma_nop;
    dma_way_i             = '0;
    dma_addr_i            = '0;
    dma_st_tag_miss_op_i  = 1'b0;
    dma_fill_then_evict_i = 1'b0;
    uncached_op_v_i       = 1'b0;
    data_v_r_i            = '0;
    dma_pkt_yumi_i        = 1'b0;
    dma_data_i            = '0;
    dma_data_v_i          = 1'b0;
    dma_data_yumi_i       = 1'b0;
    for (int w = 0; w < `WAYS; w++) begin
      for (int s = 0; s < `SETS; s++) begin
        filled[w][s] = 1'b0;
      end
    end
    repeat (3) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    next_cycle();
    for (int n = 0; n < NUM_CMDS; n++) begin
      run_random_cmd();
    end
    $display("errors: value %0d, missing done %0d, other %0d",
             value_errors, done_errors, other_errors);
    if (value_errors + done_errors + other_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

/* testbench/cache_dma_asserts.sv */
// handshake and reset assertions for the cache DMA top level
`timescale 1ns/1ps
`include "cache_dma_consts.svh"

module cache_dma_asserts (
  input logic                   clk_i,
  input logic                   reset_i,
  input logic                   done_o,
  input logic                   dma_pkt_v_o,
  input logic [`DATA_WIDTH-1:0] dma_data_o,
  input logic                   dma_data_v_o,
  input logic                   dma_data_yumi_i,
  input logic                   dma_evict_o
);

  // outgoing word holds until yumi
  data_hold_a: assert property (@(posedge clk_i) disable iff (reset_i)
      dma_data_v_o && !dma_data_yumi_i |=> dma_data_v_o && $stable(dma_data_o))
    else $error("outgoing data dropped or changed before yumi");

  // no address packet while a block is being evicted
  evict_no_pkt_a: assert property (@(posedge clk_i) disable iff (reset_i)
      dma_evict_o |-> !dma_pkt_v_o)
    else $error("packet valid during an evict");

  reset_quiet_a: assert property (@(posedge clk_i)
      reset_i |=> !(done_o || dma_pkt_v_o || dma_data_v_o || dma_evict_o))
    else $error("outputs active right after reset");

endmodule

bind cache_dma_top cache_dma_asserts cache_dma_asserts_inst (.*);

/* hdl/cache_dma_top.sv */
// cache DMA subsystem top, engine joined to the set-associative data memory
`timescale 1ns/1ps
`include "cache_dma_consts.svh"

module cache_dma_top (
  input  logic                     clk_i,
  input  logic                     reset_i,
  // miss controller command
  input  cache_dma_pkg::dma_cmd_e  dma_cmd_i,
  input  logic [`WAY_WIDTH-1:0]    dma_way_i,
  input  logic [`ADDR_WIDTH-1:0]   dma_addr_i,
  input  logic                     dma_st_tag_miss_op_i,
  input  logic                     dma_fill_then_evict_i,
  input  logic                     uncached_op_v_i,
  input  logic [`DATA_WIDTH-1:0]   data_v_r_i,
  output logic                     done_o,
  output logic [`DATA_WIDTH-1:0]   snoop_word_o,
  // external memory port
  output cache_dma_pkg::dma_pkt_s  dma_pkt_o,
  output logic                     dma_pkt_v_o,
  input  logic                     dma_pkt_yumi_i,
  input  logic [`DATA_WIDTH-1:0]   dma_data_i,
  input  logic                     dma_data_v_i,
  output logic                     dma_data_ready_and_o,
  output logic [`DATA_WIDTH-1:0]   dma_data_o,
  output logic                     dma_data_v_o,
  input  logic                     dma_data_yumi_i,
  output logic                     dma_evict_o
);

  dma_mem_if mem_bus ();

  cache_dma_engine cache_dma_engine_inst (
    .clk_i                 (clk_i),
    .reset_i               (reset_i),
    .dma_cmd_i             (dma_cmd_i),
    .dma_way_i             (dma_way_i),
    .dma_addr_i            (dma_addr_i),
    .dma_st_tag_miss_op_i  (dma_st_tag_miss_op_i),
    .dma_fill_then_evict_i (dma_fill_then_evict_i),
    .uncached_op_v_i       (uncached_op_v_i),
    .data_v_r_i            (data_v_r_i),
    .done_o                (done_o),
    .snoop_word_o          (snoop_word_o),
    .dma_pkt_o             (dma_pkt_o),
    .dma_pkt_v_o           (dma_pkt_v_o),
    .dma_pkt_yumi_i        (dma_pkt_yumi_i),
    .dma_data_i            (dma_data_i),
    .dma_data_v_i          (dma_data_v_i),
    .dma_data_ready_and_o  (dma_data_ready_and_o),
    .dma_data_o            (dma_data_o),
    .dma_data_v_o          (dma_data_v_o),
    .dma_data_yumi_i       (dma_data_yumi_i),
    .mem_if                (mem_bus.engine),
    .dma_evict_o           (dma_evict_o)
  );

  cache_data_mem cache_data_mem_inst (
    .clk_i  (clk_i),
    .mem_if (mem_bus.mem)
  );

endmodule

/* cache_dma/cache_dma_engine.sv */
// cache DMA engine moving blocks and I/O words between data memory and external memory
`timescale 1ns/1ps
`include "cache_dma_consts.svh"

module cache_dma_engine (
  input  logic                     clk_i,
  input  logic                     reset_i,
  input  cache_dma_pkg::dma_cmd_e  dma_cmd_i,
  input  logic [`WAY_WIDTH-1:0]    dma_way_i,
  input  logic [`ADDR_WIDTH-1:0]   dma_addr_i,
  input  logic                     dma_st_tag_miss_op_i,
  input  logic                     dma_fill_then_evict_i,
  input  logic                     uncached_op_v_i,
  input  logic [`DATA_WIDTH-1:0]   data_v_r_i,
  output logic                     done_o,
  output logic [`DATA_WIDTH-1:0]   snoop_word_o,
  output cache_dma_pkg::dma_pkt_s  dma_pkt_o,
  output logic                     dma_pkt_v_o,
  input  logic                     dma_pkt_yumi_i,
  input  logic [`DATA_WIDTH-1:0]   dma_data_i,
  input  logic                     dma_data_v_i,
  output logic                     dma_data_ready_and_o,
  output logic [`DATA_WIDTH-1:0]   dma_data_o,
  output logic                     dma_data_v_o,
  input  logic                     dma_data_yumi_i,
  dma_mem_if.engine                mem_if,
  output logic                     dma_evict_o
);

  import cache_dma_pkg::*;

  localparam int CNT_WIDTH = $clog2(`BLOCK_WORDS + 1);

  typedef enum logic [2:0] {
    IDLE,
    GET_FILL_DATA,
    SEND_EVICT_DATA,
    IO_GET_SNOOP_DATA,
    IO_SEND_DATA
  } state_e;

  state_e                 state_r;
  state_e                 state_n;

  logic [CNT_WIDTH-1:0]   counter_r;
  logic                   counter_clear;
  logic                   counter_up;
  logic                   counter_fill_max;
  logic                   counter_evict_max;

  logic                   in_fifo_v;
  logic [`DATA_WIDTH-1:0] in_fifo_data;
  logic                   in_fifo_yumi;
  logic                   out_fifo_v;
  logic                   out_fifo_ready;
  logic [`DATA_WIDTH-1:0] out_fifo_data;

  logic [`WAYS-1:0]       way_onehot;
  logic                   snoop_we;

  // in fifo holds a whole burst
  dma_fifo #(
    .DEPTH(`BLOCK_WORDS),
    .WIDTH(`DATA_WIDTH)
  ) in_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (dma_data_v_i),
    .data_i  (dma_data_i),
    .ready_o (dma_data_ready_and_o),
    .v_o     (in_fifo_v),
    .data_o  (in_fifo_data),
    .yumi_i  (in_fifo_yumi)
  );

  dma_fifo #(
    .DEPTH(2),
    .WIDTH(`DATA_WIDTH)
  ) out_fifo (
    .clk_i   (clk_i),
    .reset_i (reset_i),
    .v_i     (out_fifo_v),
    .data_i  (out_fifo_data),
    .ready_o (out_fifo_ready),
    .v_o     (dma_data_v_o),
    .data_o  (dma_data_o),
    .yumi_i  (dma_data_yumi_i)
  );

  assign counter_fill_max  = (counter_r == CNT_WIDTH'(`BLOCK_WORDS - 1));
  assign counter_evict_max = (counter_r == CNT_WIDTH'(`BLOCK_WORDS));

  // memory word index is the set from the address, then the burst count
  assign mem_if.mem_addr  = {dma_addr_i[`BLOCK_OFFSET_WIDTH +: `SET_WIDTH],
                             counter_r[`WORD_OFFSET_WIDTH-1:0]};
  assign mem_if.mem_wdata = in_fifo_data;
  assign way_onehot       = `WAYS'(1'b1) << dma_way_i;

  always_comb begin
    for (int w = 0; w < `WAYS; w++) begin
      mem_if.mem_w_mask[w] = {`MASK_WIDTH{way_onehot[w]}};
    end
  end

  assign out_fifo_data = uncached_op_v_i ? data_v_r_i : mem_if.mem_rdata[dma_way_i];

  always_comb begin
    state_n        = state_r;
    done_o         = 1'b0;
    dma_pkt_v_o    = 1'b0;
    dma_evict_o    = 1'b0;
    mem_if.mem_v   = 1'b0;
    mem_if.mem_w   = 1'b0;
    in_fifo_yumi   = 1'b0;
    out_fifo_v     = 1'b0;
    counter_clear  = 1'b0;
    counter_up     = 1'b0;
    snoop_we       = 1'b0;

    dma_pkt_o.write_not_read = 1'b0;
    dma_pkt_o.write_validate = 1'b0;
    dma_pkt_o.evict_pending  = 1'b0;
    dma_pkt_o.uncached_op    = uncached_op_v_i;
    dma_pkt_o.way_id         = dma_way_i;
    // uncached ops address a single word
    dma_pkt_o.addr = uncached_op_v_i
        ? {dma_addr_i[`ADDR_WIDTH-1:`BYTE_OFFSET_WIDTH], {`BYTE_OFFSET_WIDTH{1'b0}}}
        : {dma_addr_i[`ADDR_WIDTH-1:`BLOCK_OFFSET_WIDTH], {`BLOCK_OFFSET_WIDTH{1'b0}}};

    unique case (state_r)
      IDLE: begin
        unique case (dma_cmd_i)
          e_dma_send_fill_addr: begin
            dma_pkt_v_o              = 1'b1;
            dma_pkt_o.write_validate = dma_st_tag_miss_op_i;
            dma_pkt_o.evict_pending  = dma_fill_then_evict_i;
            done_o                   = dma_pkt_yumi_i;
          end
          e_dma_send_evict_addr: begin
            dma_pkt_v_o              = 1'b1;
            dma_pkt_o.write_not_read = 1'b1;
            done_o                   = dma_pkt_yumi_i;
          end
          e_dma_get_fill_data: begin
            counter_clear = 1'b1;
            state_n       = GET_FILL_DATA;
          end
          e_dma_send_evict_data: begin
            // word 0 read now, count starts at 1
            counter_clear = 1'b1;
            counter_up    = 1'b1;
            mem_if.mem_v  = 1'b1;
            state_n       = SEND_EVICT_DATA;
          end
          e_dma_recv_io_data: begin
            counter_clear = 1'b1;
            state_n       = IO_GET_SNOOP_DATA;
          end
          e_dma_send_io_data: begin
            counter_clear = 1'b1;
            state_n       = IO_SEND_DATA;
          end
          default: begin
            state_n = IDLE;
          end
        endcase
      end

      // one word written per cycle at the fifo head
      GET_FILL_DATA: begin
        mem_if.mem_v  = in_fifo_v;
        mem_if.mem_w  = in_fifo_v;
        in_fifo_yumi  = in_fifo_v;
        counter_up    = in_fifo_v & ~counter_fill_max;
        counter_clear = in_fifo_v & counter_fill_max;
        done_o        = in_fifo_v & counter_fill_max;
        snoop_we      = in_fifo_v & (counter_r[`WORD_OFFSET_WIDTH-1:0]
                        == dma_addr_i[`BYTE_OFFSET_WIDTH +: `WORD_OFFSET_WIDTH]);
        if (in_fifo_v & counter_fill_max) begin
          state_n = IDLE;
        end
      end

      // push the word read last, read the next one
      SEND_EVICT_DATA: begin
        dma_evict_o   = 1'b1;
        out_fifo_v    = 1'b1;
        mem_if.mem_v  = out_fifo_ready & ~counter_evict_max;
        counter_up    = out_fifo_ready & ~counter_evict_max;
        counter_clear = out_fifo_ready & counter_evict_max;
        done_o        = out_fifo_ready & counter_evict_max;
        if (out_fifo_ready & counter_evict_max) begin
          state_n = IDLE;
        end
      end

      IO_GET_SNOOP_DATA: begin
        in_fifo_yumi = in_fifo_v;
        snoop_we     = in_fifo_v;
        done_o       = in_fifo_v;
        if (in_fifo_v) begin
          state_n = IDLE;
        end
      end

      IO_SEND_DATA: begin
        out_fifo_v = 1'b1;
        done_o     = out_fifo_ready;
        if (out_fifo_ready) begin
          state_n = IDLE;
        end
      end

      default: begin
        state_n = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r   <= IDLE;
      counter_r <= '0;
    end else begin
      state_r <= state_n;
      if (counter_clear) begin
        counter_r <= CNT_WIDTH'(counter_up);
      end else if (counter_up) begin
        counter_r <= counter_r + 1'b1;
      end
    end
  end

  // requested word kept for the load, no second memory read
  always_ff @(posedge clk_i) begin
    if (snoop_we) begin
      snoop_word_o <= in_fifo_data;
    end
  end

endmodule

/* hdl/cache_data_mem.sv */
// cache data memory, all ways read together, byte-masked writes per way
`timescale 1ns/1ps
`include "cache_dma_consts.svh"

module cache_data_mem (
  input  logic      clk_i,
  dma_mem_if.mem    mem_if
);

  localparam int DEPTH = `SETS * `BLOCK_WORDS;

  logic [`DATA_WIDTH-1:0]            ram_r [`WAYS][DEPTH];
  logic [`WAYS-1:0][`DATA_WIDTH-1:0] rdata_r;

  // registered read output holds until the next read
  assign mem_if.mem_rdata = rdata_r;

  always_ff @(posedge clk_i) begin
    if (mem_if.mem_v) begin
      if (mem_if.mem_w) begin
        for (int w = 0; w < `WAYS; w++) begin
          for (int b = 0; b < `MASK_WIDTH; b++) begin
            if (mem_if.mem_w_mask[w][b]) begin
              ram_r[w][mem_if.mem_addr][8*b +: 8] <= mem_if.mem_wdata[8*b +: 8];
            end
          end
        end
      end else begin
        // every way read at the same index
        for (int w = 0; w < `WAYS; w++) begin
          rdata_r[w] <= ram_r[w][mem_if.mem_addr];
        end
      end
    end
  end

endmodule

/* hdl/dma_fifo.sv */
// small circular FIFO with valid/ready on the write side and valid/yumi on the read side
`timescale 1ns/1ps

module dma_fifo #(
  parameter int DEPTH = 2,
  parameter int WIDTH = 32
) (
  input  logic             clk_i,
  input  logic             reset_i,
  input  logic             v_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             ready_o,
  output logic             v_o,
  output logic [WIDTH-1:0] data_o,
  input  logic             yumi_i
);

  localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_WIDTH = $clog2(DEPTH + 1);

  logic [WIDTH-1:0]     buf_r [DEPTH];
  logic [PTR_WIDTH-1:0] wr_ptr_r;
  logic [PTR_WIDTH-1:0] rd_ptr_r;
  logic [CNT_WIDTH-1:0] count_r;
  logic                 push;

  assign ready_o = (count_r != CNT_WIDTH'(DEPTH));
  assign v_o     = (count_r != '0);
  assign data_o  = buf_r[rd_ptr_r];
  assign push    = v_i & ready_o;

  // pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [PTR_WIDTH-1:0] ptr_inc(input logic [PTR_WIDTH-1:0] ptr);
    return (ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) begin
        wr_ptr_r <= ptr_inc(wr_ptr_r);
      end
      // yumi only arrives while the head is valid
      if (yumi_i) begin
        rd_ptr_r <= ptr_inc(rd_ptr_r);
      end
      if (push & ~yumi_i) begin
        count_r <= count_r + 1'b1;
      end else if (~push & yumi_i) begin
        count_r <= count_r - 1'b1;
      end
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      buf_r[wr_ptr_r] <= data_i;
    end
  end

endmodule

/* common/dma_mem_if.sv */
// DMA engine to cache data memory port, one write word shared by all ways
`timescale 1ns/1ps
`include "cache_dma_consts.svh"

interface dma_mem_if;

  logic                                 mem_v;
  logic                                 mem_w;
  logic [`MEM_ADDR_WIDTH-1:0]           mem_addr;
  // byte enables per way
  logic [`WAYS-1:0][`MASK_WIDTH-1:0]    mem_w_mask;
  logic [`DATA_WIDTH-1:0]               mem_wdata;
  // one word per way, valid the cycle after a read
  logic [`WAYS-1:0][`DATA_WIDTH-1:0]    mem_rdata;

  modport engine (
    output mem_v,
    output mem_w,
    output mem_addr,
    output mem_w_mask,
    output mem_wdata,
    input  mem_rdata
  );

  modport mem (
    input  mem_v,
    input  mem_w,
    input  mem_addr,
    input  mem_w_mask,
    input  mem_wdata,
    output mem_rdata
  );

endinterface

/* common/cache_dma_pkg.sv */
// cache DMA types: miss controller command and outgoing memory packet
`include "cache_dma_consts.svh"

package cache_dma_pkg;

  // commands from the miss controller
  typedef enum logic [2:0] {
    e_dma_nop,
    e_dma_send_fill_addr,
    e_dma_send_evict_addr,
    e_dma_get_fill_data,
    e_dma_send_evict_data,
    e_dma_recv_io_data,
    e_dma_send_io_data
  } dma_cmd_e;

  // address packet toward external memory
  typedef struct packed {
    logic                   write_not_read;
    // store miss, block will be overwritten
    logic                   write_validate;
    // an evict follows this fill
    logic                   evict_pending;
    logic                   uncached_op;
    logic [`WAY_WIDTH-1:0]  way_id;
    logic [`ADDR_WIDTH-1:0] addr;
  } dma_pkt_s;

endpackage

/* common/cache_dma_consts.svh */
// cache DMA sizes: address, word and block widths, set and way counts, derived fields
`ifndef CACHE_DMA_CONSTS_SVH
`define CACHE_DMA_CONSTS_SVH

// base sizes
`define ADDR_WIDTH 32
`define DATA_WIDTH 32
`define BLOCK_WORDS 4
`define SETS 16
`define WAYS 2

// fields derived from the base sizes
`define BYTE_OFFSET_WIDTH 2
`define WORD_OFFSET_WIDTH 2
`define BLOCK_OFFSET_WIDTH (`BYTE_OFFSET_WIDTH + `WORD_OFFSET_WIDTH)
`define SET_WIDTH 4
`define WAY_WIDTH 1
`define MASK_WIDTH (`DATA_WIDTH / 8)

// data memory word index is set then word
`define MEM_ADDR_WIDTH (`SET_WIDTH + `WORD_OFFSET_WIDTH)

`endif
